// ==== logic/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

  // --------------------
  // field widths of the write port
  // --------------------

  // transaction id carried from AW to B
  localparam int id_w = 4;
  localparam int data_w = 16;
  // one strobe bit per data byte
  localparam int strb_w = 2;
  // awlen holds beats minus one
  localparam int len_w = 8;

  // --------------------
  // protocol encodings
  // --------------------

  localparam logic [1:0] burst_fixed = 2'b00;
  localparam logic [1:0] burst_incr = 2'b01;
  localparam logic [1:0] burst_wrap = 2'b10;

  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

endpackage

`default_nettype wire

// ==== logic/stripe_pkg.sv ====
`default_nettype none

package stripe_pkg;

  // --------------------
  // striping geometry
  // --------------------

  // flat byte address seen on the write and read ports
  localparam int addr_w = 8;
  localparam int num_banks = 4;
  localparam int bank_sel_w = 2;
  // byte address inside one bank, word index plus byte offset
  localparam int bank_addr_w = 6;
  localparam int bank_depth = 32;
  localparam int word_w = 5;

  // a flat address either taken as a whole or split into its stripe fields
  // the low word-index bits pick the bank, so consecutive words land in
  // consecutive banks and the upper bits give the word inside that bank
  typedef union packed {
    logic [addr_w-1:0] flat;
    struct packed {
      logic [word_w-1:0] bank_word;
      logic [bank_sel_w-1:0] bank_sel;
      // byte inside a 16-bit word, zero for full-width transfers
      logic byte_off;
    } f;
  } stripe_addr_t;

endpackage

`default_nettype wire

// ==== logic/axi_wr_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// write channels between the striping writer and one bank
interface axi_wr_if
  import axi_pkg::*, stripe_pkg::*;
();

  // address channel, the address is already bank-local
  logic awvalid;
  logic [bank_addr_w-1:0] awaddr;
  logic [id_w-1:0] awid;
  logic [len_w-1:0] awlen;
  logic [1:0] awburst;
  logic awready;

  // data channel
  logic wvalid;
  logic [data_w-1:0] wdata;
  logic [strb_w-1:0] wstrb;
  logic wlast;
  logic wready;

  // response channel
  logic bvalid;
  logic [id_w-1:0] bid;
  logic [1:0] bresp;
  logic bready;

  // the writer side drives the requests and takes the response
  modport manager (
    output awvalid, awaddr, awid, awlen, awburst, input awready,
    output wvalid, wdata, wstrb, wlast, input wready,
    input bvalid, bid, bresp, output bready
  );

  // the bank side
  modport subordinate (
    input awvalid, awaddr, awid, awlen, awburst, output awready,
    input wvalid, wdata, wstrb, wlast, output wready,
    output bvalid, bid, bresp, input bready
  );

endinterface

`default_nettype wire

// ==== logic/stripe_burst_split.sv ====
`default_nettype none
`timescale 1ns/1ps

// works out, for one write burst, what each bank has to do
module stripe_burst_split
  import axi_pkg::*, stripe_pkg::*;
(
  input  stripe_addr_t                          addr,
  input  logic [len_w-1:0]                      len,
  output logic [bank_sel_w-1:0]                 start_sel,
  output logic [num_banks-1:0]                  bank_valid,
  output logic [num_banks-1:0][bank_addr_w-1:0] bank_addr,
  output logic [num_banks-1:0][len_w-1:0]       bank_len
);

  // beat 0 goes to the bank named by the address
  assign start_sel = addr.f.bank_sel;

  always_comb begin
    for (int i = 0; i < num_banks; i++) begin
      logic [bank_sel_w-1:0] off;
      logic [word_w-1:0] word;

      // position of this bank in the rotation, wraps modulo num_banks
      off = bank_sel_w'(i) - addr.f.bank_sel;

      // banks below the start bank are only reached after the wrap,
      // so their first beat lands one word further up
      word = addr.f.bank_word + word_w'(bank_sel_w'(i) < addr.f.bank_sel);

      // the bank takes beats off, off+4, off+8 and so on up to len
      bank_valid[i] = len >= len_w'(off);
      bank_addr[i] = {word, addr.f.byte_off};

      // beats seen by this bank minus one, left at zero when it sits out
      if (bank_valid[i]) begin
        bank_len[i] = (len - len_w'(off)) >> bank_sel_w;
      end else begin
        bank_len[i] = '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/skid_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

// two-entry buffer for write data and strobe
module skid_buffer
  import axi_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  logic [data_w+strb_w-1:0] in_data,
  output logic                     in_ready,
  output logic                     out_valid,
  output logic [data_w+strb_w-1:0] out_data,
  input  logic                     out_ready
);

  // second slot, filled only when the output is stalled
  logic skid_valid;
  logic [data_w+strb_w-1:0] skid_data;
  logic in_fire;
  logic out_open;

  // in_ready comes straight from a flop, never from out_ready
  assign in_ready = !skid_valid;
  assign in_fire = in_valid && in_ready;
  assign out_open = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_open) begin
      // drain the skid slot first, upstream is already held off
      if (skid_valid) begin
        out_valid <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        out_valid <= in_fire;
      end
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_open) begin
      out_data <= skid_valid ? skid_data : in_data;
    end
    if (!out_open && in_fire) begin
      skid_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== logic/stripe_wr.sv ====
`default_nettype none
`timescale 1ns/1ps

// spreads one write burst over the banks and merges their responses
module stripe_wr
  import axi_pkg::*, stripe_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              s_awvalid,
  input  logic [addr_w-1:0] s_awaddr,
  input  logic [id_w-1:0]   s_awid,
  input  logic [len_w-1:0]  s_awlen,
  input  logic [1:0]        s_awburst,
  output logic              s_awready,
  input  logic              s_wvalid,
  input  logic [data_w-1:0] s_wdata,
  input  logic [strb_w-1:0] s_wstrb,
  output logic              s_wready,
  output logic              s_bvalid,
  output logic [id_w-1:0]   s_bid,
  output logic [1:0]        s_bresp,
  input  logic              s_bready,
  axi_wr_if.manager         bank_bus [num_banks]
);

  stripe_addr_t aw_addr;
  logic aw_fire;
  logic b_fire;
  logic [bank_sel_w-1:0] start_sel;
  logic [num_banks-1:0] split_valid;
  logic [num_banks-1:0][bank_addr_w-1:0] split_addr;
  logic [num_banks-1:0][len_w-1:0] split_len;

  // per-bank request registers, id and burst type are shared by all banks
  logic [num_banks-1:0] aw_valid_q;
  logic [num_banks-1:0][bank_addr_w-1:0] aw_addr_q;
  logic [num_banks-1:0][len_w-1:0] aw_len_q;
  logic [id_w-1:0] aw_id_q;
  logic [1:0] aw_burst_q;

  // incoming data window and skid buffer
  logic w_open;
  logic [len_w-1:0] w_in_rem;
  logic sb_in_valid;
  logic sb_in_ready;
  logic sb_out_valid;
  logic sb_out_ready;
  logic [data_w+strb_w-1:0] sb_out_data;

  // routing state and per-bank data registers
  logic w_busy;
  logic route;
  logic [bank_sel_w-1:0] w_idx;
  logic [len_w-1:0] w_rem;
  logic [num_banks-1:0] wv_q;
  logic [num_banks-1:0] wlast_q;
  logic [num_banks-1:0][data_w-1:0] wdata_q;
  logic [num_banks-1:0][strb_w-1:0] wstrb_q;

  // bank side handshakes gathered into vectors
  logic [num_banks-1:0] bank_awready;
  logic [num_banks-1:0] bank_wready;
  logic [num_banks-1:0] bank_bvalid;
  logic [num_banks-1:0][id_w-1:0] bank_bid;
  logic [num_banks-1:0][1:0] bank_bresp;
  logic [num_banks-1:0] b_done;
  logic [num_banks-1:0] b_done_next;

  for (genvar i = 0; i < num_banks; i++) begin : gen_bus
    assign bank_bus[i].awvalid = aw_valid_q[i];
    assign bank_bus[i].awaddr = aw_addr_q[i];
    assign bank_bus[i].awid = aw_id_q;
    assign bank_bus[i].awlen = aw_len_q[i];
    assign bank_bus[i].awburst = aw_burst_q;
    assign bank_bus[i].wvalid = wv_q[i];
    assign bank_bus[i].wdata = wdata_q[i];
    assign bank_bus[i].wstrb = wstrb_q[i];
    assign bank_bus[i].wlast = wlast_q[i];
    // responses are buffered here, so the banks never wait on B
    assign bank_bus[i].bready = 1'b1;
    assign bank_awready[i] = bank_bus[i].awready;
    assign bank_wready[i] = bank_bus[i].wready;
    assign bank_bvalid[i] = bank_bus[i].bvalid;
    assign bank_bid[i] = bank_bus[i].bid;
    assign bank_bresp[i] = bank_bus[i].bresp;
  end

  // --------------------
  // AW channel
  // --------------------

  assign aw_addr.flat = s_awaddr;
  assign aw_fire = s_awvalid && s_awready;
  assign b_fire = s_bvalid && s_bready;

  stripe_burst_split u_split (
    .addr       (aw_addr),
    .len        (s_awlen),
    .start_sel  (start_sel),
    .bank_valid (split_valid),
    .bank_addr  (split_addr),
    .bank_len   (split_len)
  );

  // one burst in flight, the port reopens the cycle after B is taken
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s_awready <= 1'b1;
      aw_valid_q <= '0;
    end else begin
      if (aw_fire) begin
        s_awready <= 1'b0;
        aw_valid_q <= split_valid;
      end else begin
        if (b_fire) begin
          s_awready <= 1'b1;
        end
        aw_valid_q <= aw_valid_q & ~bank_awready;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      aw_addr_q <= split_addr;
      aw_len_q <= split_len;
      aw_id_q <= s_awid;
      aw_burst_q <= s_awburst;
    end
  end

  // --------------------
  // W channel
  // --------------------

  // data is only taken while the accepted burst still owes beats
  assign s_wready = w_open && sb_in_ready;
  assign sb_in_valid = s_wvalid && w_open;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_open <= 1'b0;
    end else if (aw_fire) begin
      w_open <= 1'b1;
      w_in_rem <= s_awlen;
    end else if (s_wvalid && s_wready) begin
      if (w_in_rem == '0) begin
        w_open <= 1'b0;
      end else begin
        w_in_rem <= w_in_rem - 1'b1;
      end
    end
  end

  skid_buffer u_skid (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (sb_in_valid),
    .in_data   ({s_wdata, s_wstrb}),
    .in_ready  (sb_in_ready),
    .out_valid (sb_out_valid),
    .out_data  (sb_out_data),
    .out_ready (sb_out_ready)
  );

  // a beat moves on when the target bank register is empty or draining
  assign sb_out_ready = w_busy && (!wv_q[w_idx] || bank_wready[w_idx]);
  assign route = sb_out_valid && sb_out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_busy <= 1'b0;
      w_idx <= '0;
      wv_q <= '0;
    end else begin
      wv_q <= wv_q & ~bank_wready;
      if (route) begin
        wv_q[w_idx] <= 1'b1;
      end
      if (aw_fire) begin
        w_busy <= 1'b1;
        w_idx <= start_sel;
        w_rem <= s_awlen;
      end else if (route) begin
        // the bank index wraps by itself since num_banks is a power of two
        w_idx <= w_idx + 1'b1;
        if (w_rem == '0) begin
          w_busy <= 1'b0;
        end else begin
          w_rem <= w_rem - 1'b1;
        end
      end
    end
  end

  // fewer than num_banks beats left means no later beat reaches this bank
  always_ff @(posedge clk) begin
    if (route) begin
      wdata_q[w_idx] <= sb_out_data[strb_w +: data_w];
      wstrb_q[w_idx] <= sb_out_data[strb_w-1:0];
      wlast_q[w_idx] <= w_rem < len_w'(num_banks);
    end
  end

  // --------------------
  // B channel
  // --------------------

  // banks left out of the burst count as answered from the start
  always_comb begin
    b_done_next = b_done;
    if (b_fire) begin
      b_done_next = '0;
    end
    if (aw_fire) begin
      b_done_next = ~split_valid;
    end
    b_done_next = b_done_next | bank_bvalid;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      b_done <= '0;
      s_bvalid <= 1'b0;
    end else begin
      b_done <= b_done_next;
      s_bvalid <= &b_done_next;
    end
  end

  // any bank error wins over okay, all banks echo the same id
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      s_bresp <= resp_okay;
    end
    for (int i = 0; i < num_banks; i++) begin
      if (bank_bvalid[i]) begin
        s_bid <= bank_bid[i];
        if (bank_bresp[i] != resp_okay) begin
          s_bresp <= bank_bresp[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/bank_mem.sv ====
`default_nettype none
`timescale 1ns/1ps

// one memory bank behind a write subordinate, with a one-cycle read port
module bank_mem
  import axi_pkg::*, stripe_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic [word_w-1:0]  rd_word,
  output logic [data_w-1:0]  rd_data,
  axi_wr_if.subordinate      bus
);

  logic [data_w-1:0] mem [bank_depth];

  // idle while both phase flags are low
  logic w_phase;
  logic b_phase;
  logic aw_fire;
  logic w_fire;
  logic incr_ok;
  logic [word_w-1:0] wr_word;
  logic [len_w-1:0] beat_rem;
  logic [id_w-1:0] bid_q;
  logic [1:0] bresp_q;

  assign bus.awready = !w_phase && !b_phase;
  assign bus.wready = w_phase;
  assign bus.bvalid = b_phase;
  assign bus.bid = bid_q;
  assign bus.bresp = bresp_q;

  assign aw_fire = bus.awvalid && bus.awready;
  assign w_fire = bus.wvalid && bus.wready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_phase <= 1'b0;
      b_phase <= 1'b0;
    end else begin
      if (aw_fire) begin
        w_phase <= 1'b1;
      end
      // the response goes out the cycle after the last beat
      if (w_fire && bus.wlast) begin
        w_phase <= 1'b0;
        b_phase <= 1'b1;
      end
      if (bus.bvalid && bus.bready) begin
        b_phase <= 1'b0;
      end
    end
  end

  // only INCR is striped, a wlast that disagrees with awlen is an error too
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_word <= bus.awaddr[bank_addr_w-1 -: word_w];
      beat_rem <= bus.awlen;
      incr_ok <= bus.awburst == burst_incr;
      bid_q <= bus.awid;
    end else if (w_fire) begin
      wr_word <= wr_word + 1'b1;
      beat_rem <= beat_rem - 1'b1;
      if (bus.wlast) begin
        bresp_q <= (incr_ok && beat_rem == '0) ? resp_okay : resp_slverr;
      end
    end
  end

  // byte lanes follow the strobe, other bursts leave the array untouched
  always_ff @(posedge clk) begin
    if (w_fire && incr_ok) begin
      for (int b = 0; b < strb_w; b++) begin
        if (bus.wstrb[b]) begin
          mem[wr_word][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
    rd_data <= mem[rd_word];
  end

endmodule

`default_nettype wire

// ==== logic/stripe_rd_port.sv ====
`default_nettype none
`timescale 1ns/1ps

// read side: every bank reads the same word, the registered select picks one
module stripe_rd_port
  import axi_pkg::*, stripe_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              rd_en,
  input  logic [addr_w-1:0]                 rd_addr,
  input  logic [num_banks-1:0][data_w-1:0]  bank_rd_data,
  output logic [word_w-1:0]                 bank_rd_word,
  output logic                              rd_valid,
  output logic [data_w-1:0]                 rd_data
);

  stripe_addr_t addr;
  logic [bank_sel_w-1:0] sel_q;

  assign addr.flat = rd_addr;
  assign bank_rd_word = addr.f.bank_word;

  // valid lines up with the banks' registered read data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      sel_q <= addr.f.bank_sel;
    end
  end

  assign rd_data = bank_rd_data[sel_q];

endmodule

`default_nettype wire

// ==== logic/striped_mem_top.sv ====
`default_nettype none
`timescale 1ns/1ps

// striped write memory, writer plus four banks plus read port
module striped_mem_top
  import axi_pkg::*, stripe_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              s_awvalid,
  input  logic [addr_w-1:0] s_awaddr,
  input  logic [id_w-1:0]   s_awid,
  input  logic [len_w-1:0]  s_awlen,
  input  logic [1:0]        s_awburst,
  output logic              s_awready,
  input  logic              s_wvalid,
  input  logic [data_w-1:0] s_wdata,
  input  logic [strb_w-1:0] s_wstrb,
  // the writer counts beats from awlen, so wlast is not looked at
  input  logic              s_wlast,
  output logic              s_wready,
  output logic              s_bvalid,
  output logic [id_w-1:0]   s_bid,
  output logic [1:0]        s_bresp,
  input  logic              s_bready,
  input  logic              rd_en,
  input  logic [addr_w-1:0] rd_addr,
  output logic              rd_valid,
  output logic [data_w-1:0] rd_data
);

  axi_wr_if bank_bus [num_banks] ();

  logic [word_w-1:0] bank_rd_word;
  logic [num_banks-1:0][data_w-1:0] bank_rd_data;

  stripe_wr u_wr (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_awvalid (s_awvalid),
    .s_awaddr  (s_awaddr),
    .s_awid    (s_awid),
    .s_awlen   (s_awlen),
    .s_awburst (s_awburst),
    .s_awready (s_awready),
    .s_wvalid  (s_wvalid),
    .s_wdata   (s_wdata),
    .s_wstrb   (s_wstrb),
    .s_wready  (s_wready),
    .s_bvalid  (s_bvalid),
    .s_bid     (s_bid),
    .s_bresp   (s_bresp),
    .s_bready  (s_bready),
    .bank_bus  (bank_bus)
  );

  for (genvar i = 0; i < num_banks; i++) begin : gen_bank
    bank_mem u_bank (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd_word (bank_rd_word),
      .rd_data (bank_rd_data[i]),
      .bus     (bank_bus[i])
    );
  end

  stripe_rd_port u_rd (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_en        (rd_en),
    .rd_addr      (rd_addr),
    .bank_rd_data (bank_rd_data),
    .bank_rd_word (bank_rd_word),
    .rd_valid     (rd_valid),
    .rd_data      (rd_data)
  );

endmodule

`default_nettype wire

// ==== test/striped_mem_properties.sv ====
`default_nettype none
`timescale 1ns/1ps

// protocol rules on the top-level ports, bound into striped_mem_top
module striped_mem_properties
  import axi_pkg::*;
(
  input wire logic            clk,
  input wire logic            rst_n,
  input wire logic            s_awready,
  input wire logic            s_wready,
  input wire logic            s_bvalid,
  input wire logic            s_bready,
  input wire logic [id_w-1:0] s_bid,
  input wire logic [1:0]      s_bresp,
  input wire logic            rd_en,
  input wire logic            rd_valid
);

  // number of failed properties, watched by the testbench
  int unsigned fail_count = 0;

  // --------------------
  // write port
  // --------------------

  // only one burst in flight, so no address is taken while a response waits
  assert property (@(posedge clk) disable iff (!rst_n) !(s_awready && s_bvalid))
    else begin
      $error("s_awready high while s_bvalid is high");
      fail_count++;
    end

  // a stalled response keeps its valid and its payload
  assert property (@(posedge clk) disable iff (!rst_n)
    s_bvalid && !s_bready |=> s_bvalid && $stable(s_bid) && $stable(s_bresp))
    else begin
      $error("write response changed under back-pressure");
      fail_count++;
    end

  // --------------------
  // read port and reset
  // --------------------

  assert property (@(posedge clk) disable iff (!rst_n) rd_en |=> rd_valid)
    else begin
      $error("rd_valid missing one cycle after rd_en");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (!rst_n) !rd_en |=> !rd_valid)
    else begin
      $error("rd_valid without rd_en in the cycle before");
      fail_count++;
    end

  // first cycle out of reset shows every handshake output idle
  assert property (@(posedge clk) $rose(rst_n) |-> !s_wready && !s_bvalid && !rd_valid)
    else begin
      $error("control output high in the cycle after reset");
      fail_count++;
    end

endmodule

bind striped_mem_top striped_mem_properties u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .s_awready (s_awready),
  .s_wready  (s_wready),
  .s_bvalid  (s_bvalid),
  .s_bready  (s_bready),
  .s_bid     (s_bid),
  .s_bresp   (s_bresp),
  .rd_en     (rd_en),
  .rd_valid  (rd_valid)
);

`default_nettype wire

// ==== test/tb_striped_mem.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_striped_mem
  import axi_pkg::*, stripe_pkg::*;
();

  localparam int num_words = num_banks * bank_depth;
  // cycles any single wait may take before the run is called hung
  localparam int wait_limit = 2000;

  logic clk;
  logic rst_n;
  logic s_awvalid;
  logic [addr_w-1:0] s_awaddr;
  logic [id_w-1:0] s_awid;
  logic [len_w-1:0] s_awlen;
  logic [1:0] s_awburst;
  logic s_awready;
  logic s_wvalid;
  logic [data_w-1:0] s_wdata;
  logic [strb_w-1:0] s_wstrb;
  logic s_wlast;
  logic s_wready;
  logic s_bvalid;
  logic [id_w-1:0] s_bid;
  logic [1:0] s_bresp;
  logic s_bready;
  logic rd_en;
  logic [addr_w-1:0] rd_addr;
  logic rd_valid;
  logic [data_w-1:0] rd_data;

  // expected contents, indexed by flat word address
  logic [data_w-1:0] shadow [num_words];
  int seed;

  striped_mem_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // checking helpers
  // --------------------

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else stop_on_error($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // a failed bound property ends the run just like a failed check here
  always @(negedge clk) begin
    if (DUT.u_props.fail_count != 0) begin
      stop_on_error("a protocol property failed");
    end
  end

  // --------------------
  // stimulus tasks
  // --------------------

  // takes the response, optionally after holding s_bready low for a while
  task automatic take_resp(input logic [id_w-1:0] id, input logic [1:0] resp, input int hold);
    int n;
    n = 0;
    while (!s_bvalid) begin
      n++;
      if (n > wait_limit) stop_on_error("timeout waiting for s_bvalid");
      @(negedge clk);
    end
    // an address offered now must stay pending until the response is gone
    repeat (hold) begin
      @(negedge clk);
      s_awvalid = 1'b1;
      check_eq("s_bvalid", s_bvalid, 1);
      check_eq("s_awready", s_awready, 0);
    end
    check_eq("s_bid", s_bid, id);
    check_eq("s_bresp", s_bresp, resp);
    s_bready = 1'b1;
    @(negedge clk);
    s_bready = 1'b0;
    s_awvalid = 1'b0;
  endtask

  // one burst starting at a flat word, beat k lands at word + k
  task automatic send_burst(input int word, input int len, input logic [1:0] burst,
                            input bit partial, input int hold);
    logic [id_w-1:0] id;
    int gap;
    int n;
    id = id_w'($random(seed));
    @(negedge clk);
    s_awvalid = 1'b1;
    s_awaddr = addr_w'(word * 2);
    s_awid = id;
    s_awlen = len_w'(len);
    s_awburst = burst;
    n = 0;
    while (!s_awready) begin
      n++;
      if (n > wait_limit) stop_on_error("timeout waiting for s_awready");
      @(negedge clk);
    end
    @(negedge clk);
    s_awvalid = 1'b0;
    for (int k = 0; k <= len; k++) begin
      gap = partial ? int'($unsigned($random(seed)) % 3) : 0;
      repeat (gap) begin
        s_wvalid = 1'b0;
        @(negedge clk);
      end
      s_wvalid = 1'b1;
      s_wdata = data_w'($random(seed));
      s_wstrb = partial ? strb_w'($random(seed)) : '1;
      s_wlast = (k == len);
      n = 0;
      while (!s_wready) begin
        n++;
        if (n > wait_limit) stop_on_error("timeout waiting for s_wready");
        @(negedge clk);
      end
      // only INCR bursts change memory, byte lanes follow the strobe
      if (burst == burst_incr) begin
        for (int b = 0; b < strb_w; b++) begin
          if (s_wstrb[b]) shadow[word + k][8*b +: 8] = s_wdata[8*b +: 8];
        end
      end
      @(negedge clk);
    end
    s_wvalid = 1'b0;
    s_wlast = 1'b0;
    take_resp(id, (burst == burst_incr) ? resp_okay : resp_slverr, hold);
  endtask

  task automatic read_check(input int word);
    int n;
    @(negedge clk);
    rd_en = 1'b1;
    rd_addr = addr_w'(word * 2);
    @(negedge clk);
    rd_en = 1'b0;
    n = 0;
    while (!rd_valid) begin
      n++;
      if (n > wait_limit) stop_on_error("timeout waiting for rd_valid");
      @(negedge clk);
    end
    check_eq($sformatf("rd_data[%0d]", word), rd_data, shadow[word]);
  endtask

  task automatic check_all();
    for (int w = 0; w < num_words; w++) begin
      read_check(w);
    end
  endtask

  // --------------------
  // test sequence
  // --------------------

  initial begin
    int len;
    int word;
    seed = 13751;
    rst_n = 1'b0;
    s_awvalid = 1'b0;
    s_awaddr = '0;
    s_awid = '0;
    s_awlen = '0;
    s_awburst = burst_incr;
    s_wvalid = 1'b0;
    s_wdata = '0;
    s_wstrb = '0;
    s_wlast = 1'b0;
    s_bready = 1'b0;
    rd_en = 1'b0;
    rd_addr = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_eq("s_awready", s_awready, 1);
    check_eq("s_bvalid", s_bvalid, 0);
    check_eq("s_wready", s_wready, 0);

    // the banks power up unknown, one long burst gives every word a value
    send_burst(0, num_words - 1, burst_incr, 1'b0, 0);
    send_burst(16, 7, burst_incr, 1'b0, 0);
    check_all();

    // word 43 sits in bank 3, so the second beat wraps into bank 0
    send_burst(43, 1, burst_incr, 1'b0, 0);
    check_all();

    // random partial strobes and gaps, kept inside the address range
    for (int i = 0; i < 6; i++) begin
      len = int'($unsigned($random(seed)) % 12);
      word = int'($unsigned($random(seed)) % (num_words - len));
      send_burst(word, len, burst_incr, 1'b1, 0);
    end
    check_all();

    send_burst(9, 3, burst_fixed, 1'b0, 0);
    check_all();

    // response held back, then a normal burst behind it
    send_burst(70, 5, burst_incr, 1'b1, 1 + int'($unsigned($random(seed)) % 8));
    send_burst(100, 9, burst_incr, 1'b0, 0);
    check_all();

    if (DUT.u_props.fail_count == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      stop_on_error("a protocol property failed");
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
logic/axi_pkg.sv
logic/stripe_pkg.sv
logic/axi_wr_if.sv
logic/stripe_burst_split.sv
logic/skid_buffer.sv
logic/stripe_wr.sv
logic/bank_mem.sv
logic/stripe_rd_port.sv
logic/striped_mem_top.sv
test/striped_mem_properties.sv
test/tb_striped_mem.sv

// ==== run.sh ====
#!/bin/sh
# builds the striped memory testbench with Verilator and runs it
# the run passes only if the log holds the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f list.f --top-module tb_striped_mem -o sim_striped_mem
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_striped_mem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -q "^Done: no errors$" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1
